/* hdl/nnTypesPkg.sv */
package nnTypesPkg;

	localparam int activationWidth = 8;
	localparam int sumWidth = 16;

	localparam int numInputs = 15;
	localparam int numNodes = 4;

	localparam int inputIndexWidth = $clog2(numInputs);
	localparam int nodeIndexWidth = $clog2(numNodes);

	typedef logic signed [activationWidth-1:0] activationT;
	typedef logic signed [activationWidth-1:0] weightT;
	typedef logic signed [sumWidth-1:0] sumT;   // Product, accumulator and result.

	typedef logic [inputIndexWidth-1:0] inputIndexT;
	typedef logic [nodeIndexWidth-1:0] nodeIndexT;

	typedef enum logic [1:0]
	{
		stLoad,   // Collecting activations.
		stBias,   // Accumulator takes the bias.
		stMac,    // One product per cycle.
		stEmit    // ReLU result goes out.
	} layerStateT;

endpackage

/* hdl/nnWeightsPkg.sv */
package nnWeightsPkg;

	// One row per neuron, one column per input.
	localparam nnTypesPkg::weightT weightTable
		[nnTypesPkg::numNodes][nnTypesPkg::numInputs] = '{
		'{
			12, -5, 33, -47, 8,
			19, -22, 4, 61, -13,
			27, -9, 40, -31, 15
		},
		'{
			-64, 18, -2, 7, -29,
			45, -11, -36, 3, 22,
			-50, 9, -17, 28, -6
		},
		'{
			5, 71, -40, 14, 0,
			-27, 38, -8, -55, 16,
			2, -33, 49, -1, -20
		},
		'{
			-7, 3, -23, -83, 0,
			-14, 31, 34, -81, -67,
			-83, 70, 6, -38, 93
		}
	};

	localparam nnTypesPkg::weightT biasTable [nnTypesPkg::numNodes] = '{
		-10,
		37,
		-4,
		21
	};

endpackage

/* hdl/macBus.sv */
interface macBus;

	nnTypesPkg::inputIndexT index;
	nnTypesPkg::nodeIndexT node;
	logic lastIndex;
	logic lastNode;

	logic advanceIndex;   // Step commands from the controller.
	logic advanceNode;

	logic clearAcc;
	logic accumulate;
	logic emit;

	nnTypesPkg::activationT activation;

	modport control
	(
		input lastIndex,
		input lastNode,
		output advanceIndex,
		output advanceNode,
		output clearAcc,
		output accumulate,
		output emit
	);

	modport counter
	(
		input advanceIndex,
		input advanceNode,
		output index,
		output node,
		output lastIndex,
		output lastNode
	);

	modport buffer
	(
		input index,
		output activation
	);

	modport mac
	(
		input index,
		input node,
		input clearAcc,
		input accumulate,
		input emit,
		input activation
	);

endinterface

/* hdl/layerControl.sv */
module layerControl
(
	input logic clk,
	input logic reset,
	input logic inValid,
	macBus.control bus,
	output logic busy,
	output logic outValid,
	output logic done
);

	nnTypesPkg::layerStateT state;
	nnTypesPkg::layerStateT nextState;

	logic inLoad;
	logic inBias;
	logic inMac;
	logic inEmit;

	assign inLoad = (state == nnTypesPkg::stLoad);
	assign inBias = (state == nnTypesPkg::stBias);
	assign inMac = (state == nnTypesPkg::stMac);
	assign inEmit = (state == nnTypesPkg::stEmit);

	always_comb
	begin
		nextState = state;
		case (state)
			nnTypesPkg::stLoad:
			begin
				if (inValid && bus.lastIndex)   // 15th activation accepted.
					nextState = nnTypesPkg::stBias;
			end
			nnTypesPkg::stBias:
			begin
				nextState = nnTypesPkg::stMac;
			end
			nnTypesPkg::stMac:
			begin
				if (bus.lastIndex)
					nextState = nnTypesPkg::stEmit;
			end
			nnTypesPkg::stEmit:
			begin
				if (bus.lastNode)
					nextState = nnTypesPkg::stLoad;
				else
					nextState = nnTypesPkg::stBias;
			end
			default:
			begin
				nextState = nnTypesPkg::stLoad;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= nnTypesPkg::stLoad;
		else
			state <= nextState;
	end

	assign busy = !inLoad;

	assign bus.clearAcc = inBias;
	assign bus.accumulate = inMac;
	assign bus.emit = inEmit;

	// Index walks once per accepted input, then once per product.
	assign bus.advanceIndex = (inLoad && inValid) || inMac;
	assign bus.advanceNode = inEmit;   // Node held until its result is out.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			outValid <= inEmit;
			done <= inEmit && bus.lastNode;   // Last neuron of the sample.
		end
	end

endmodule

/* hdl/stepCounter.sv */
module stepCounter
(
	input logic clk,
	input logic reset,
	macBus.counter bus
);

	localparam nnTypesPkg::inputIndexT lastIndexValue =
		nnTypesPkg::inputIndexT'(nnTypesPkg::numInputs - 1);
	localparam nnTypesPkg::nodeIndexT lastNodeValue =
		nnTypesPkg::nodeIndexT'(nnTypesPkg::numNodes - 1);

	assign bus.lastIndex = (bus.index == lastIndexValue);
	assign bus.lastNode = (bus.node == lastNodeValue);

	always_ff @(posedge clk)
	begin
		if (reset)
			bus.index <= '0;
		else if (bus.advanceIndex)
		begin
			if (bus.lastIndex)
				bus.index <= '0;
			else
				bus.index <= bus.index + 1'b1;
		end
	end

	// Steps once per finished neuron and wraps back for the next sample.
	always_ff @(posedge clk)
	begin
		if (reset)
			bus.node <= '0;
		else if (bus.advanceNode)
		begin
			if (bus.lastNode)
				bus.node <= '0;
			else
				bus.node <= bus.node + 1'b1;
		end
	end

endmodule

/* hdl/activationBuffer.sv */
module activationBuffer
(
	input logic clk,
	input logic inValid,
	input nnTypesPkg::activationT inData,
	input logic busy,
	macBus.buffer bus
);

	nnTypesPkg::activationT entries [nnTypesPkg::numInputs];

	logic writeEnable;

	assign writeEnable = inValid && !busy;   // Strobes during compute are dropped.

	always_ff @(posedge clk)
	begin
		if (writeEnable)
			entries[bus.index] <= inData;
	end

	// Read port follows the shared index.
	assign bus.activation = entries[bus.index];

endmodule

/* hdl/neuronMac.sv */
module neuronMac
(
	input logic clk,
	input logic reset,
	macBus.mac bus,
	output nnTypesPkg::nodeIndexT outNode,
	output nnTypesPkg::sumT outData
);

	nnTypesPkg::weightT weight;
	nnTypesPkg::weightT bias;
	nnTypesPkg::sumT product;
	nnTypesPkg::sumT acc;
	nnTypesPkg::sumT relu;

	assign weight = nnWeightsPkg::weightTable[bus.node][bus.index];
	assign bias = nnWeightsPkg::biasTable[bus.node];

	// Operands widened to 16 bits first so the product keeps its sign.
	assign product = nnTypesPkg::sumT'(bus.activation) * nnTypesPkg::sumT'(weight);

	always_ff @(posedge clk)
	begin
		if (bus.clearAcc)
			acc <= nnTypesPkg::sumT'(bias);   // Sign-extended.
		else if (bus.accumulate)
			acc <= acc + product;   // Wraps at 16 bits.
	end

	assign relu = acc[nnTypesPkg::sumWidth-1] ? '0 : acc;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outData <= '0;
			outNode <= '0;
		end
		else if (bus.emit)
		begin
			outData <= relu;
			outNode <= bus.node;
		end
	end

endmodule

/* hdl/denseLayer.sv */
module denseLayer
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnTypesPkg::activationT inData,
	output logic busy,
	output logic outValid,
	output nnTypesPkg::nodeIndexT outNode,
	output nnTypesPkg::sumT outData,
	output logic done
);

	macBus layerBus();

	layerControl u_layerControl
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.bus(layerBus.control),
		.busy(busy),
		.outValid(outValid),
		.done(done)
	);

	stepCounter u_stepCounter
	(
		.clk(clk),
		.reset(reset),
		.bus(layerBus.counter)
	);

	// Write side is gated by busy from the controller.
	activationBuffer u_activationBuffer
	(
		.clk(clk),
		.inValid(inValid),
		.inData(inData),
		.busy(busy),
		.bus(layerBus.buffer)
	);

	neuronMac u_neuronMac
	(
		.clk(clk),
		.reset(reset),
		.bus(layerBus.mac),
		.outNode(outNode),
		.outData(outData)
	);

endmodule

/* tests/denseLayer_assertions.sv */
module denseLayerAssertions
(
	input logic clk,
	input logic reset,
	input logic outValid,
	input logic done,
	input nnTypesPkg::nodeIndexT outNode,
	input nnTypesPkg::sumT outData
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam nnTypesPkg::nodeIndexT lastNode =
		nnTypesPkg::nodeIndexT'(nnTypesPkg::numNodes - 1);

	singlePulse: assert property (@(posedge clk) disable iff (reset)
		outValid |=> !outValid)
		else $error("outValid stayed high for more than one cycle");

	// Done marks the last neuron only.
	doneWithLast: assert property (@(posedge clk) disable iff (reset)
		done |-> (outValid && outNode == lastNode))
		else $error("done without outValid of the last neuron");

	nonNegative: assert property (@(posedge clk) disable iff (reset)
		!outData[nnTypesPkg::sumWidth-1])
		else $error("outData is negative after ReLU");

endmodule

bind denseLayer denseLayerAssertions u_denseLayerAssertions
(
	.clk(clk),
	.reset(reset),
	.outValid(outValid),
	.done(done),
	.outNode(outNode),
	.outData(outData)
);

/* tests/denseLayerTb.sv */
module denseLayerTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int numInputs = nnTypesPkg::numInputs;
	localparam int numNodes = nnTypesPkg::numNodes;
	localparam int recordWords = numInputs + numNodes;
	localparam int numRecords = 6;
	localparam int nodeCycles = 17;   // Bias, 15 products, emit.
	localparam int timeoutCycles = 60;

	logic clk;
	logic reset;
	logic inValid;
	logic [7:0] inData;
	logic busy;
	logic outValid;
	logic [1:0] outNode;
	logic [15:0] outData;
	logic done;

	logic [15:0] vectorMem [numRecords * recordWords];
	int cycleCount;
	int errorCount;
	int testCount;
	int failedTests;

	denseLayer u_denseLayer
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.busy(busy),
		.outValid(outValid),
		.outNode(outNode),
		.outData(outData),
		.done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
		cycleCount <= cycleCount + 1;   // Read only at falling edges.

	task automatic checkValue(input string label, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED %s: expected %0h, actual %0h", label, expected, actual);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore)
			$display("%s: ok", name);
		else
		begin
			failedTests++;
			$display("%s: %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	// Starts and ends on a falling edge, so samples can follow each other directly.
	task automatic runRecord(input int rec, input bit withGaps, input bit withNoise,
		input string name);
		int base;
		int acceptCycle;
		int lastPulse;
		int nodeSeen;
		int waitCycles;
		string label;
		base = rec * recordWords;
		for (int i = 0; i < numInputs; i++)
		begin
			checkValue({name, " busy while loading"}, 0, busy);
			inValid = 1'b1;
			inData = vectorMem[base + i][7:0];
			if (i == numInputs - 1)
				acceptCycle = cycleCount + 1;
			@(negedge clk);
			if (withGaps && i < numInputs - 1)
			begin
				inValid = 1'b0;
				inData = 8'hA5;   // Ignored filler.
				repeat (i % 3 + 1) @(negedge clk);
			end
		end
		inValid = 1'b0;
		nodeSeen = 0;
		lastPulse = acceptCycle;
		waitCycles = 0;
		while (nodeSeen < numNodes && waitCycles < timeoutCycles)
		begin
			if (outValid)
			begin
				label = $sformatf("%s node %0d", name, nodeSeen);
				checkValue({label, " number"}, nodeSeen, outNode);
				checkValue({label, " data"}, vectorMem[base + numInputs + nodeSeen], outData);
				checkValue({label, " interval"}, nodeCycles, cycleCount - lastPulse);
				checkValue({label, " done"}, nodeSeen == numNodes - 1, done);
				checkValue({label, " busy"}, nodeSeen != numNodes - 1, busy);
				lastPulse = cycleCount;
				nodeSeen++;
				waitCycles = 0;
			end
			if (nodeSeen < numNodes)
			begin
				if (withNoise)
				begin
					inValid = ~inValid;
					inData = 8'(cycleCount * 29 + 7);
				end
				@(negedge clk);
				waitCycles++;
			end
		end
		inValid = 1'b0;
		if (nodeSeen < numNodes)
		begin
			$display("Timeout in %s: neuron %0d gave no result within %0d cycles",
				name, nodeSeen, timeoutCycles);
			errorCount++;
		end
	endtask

	initial
	begin
		int errorsBefore;
		string name;
		reset = 1'b1;
		inValid = 1'b0;
		inData = '0;
		for (int a = 0; a < numRecords * recordWords; a++)
			vectorMem[a] = 16'h8000 | 16'(a);   // Bit 15 marks a word the file did not fill.
		$readmemh("tests/denseLayer_vectors.txt", vectorMem);
		if (vectorMem[numRecords * recordWords - 1][15])
		begin
			$display("Vector file tests/denseLayer_vectors.txt could not be read");
			errorCount++;
		end
		repeat (8) @(negedge clk);
		reset = 1'b0;

		errorsBefore = errorCount;
		for (int i = 0; i < 3; i++)
		begin
			checkValue("reset busy", 0, busy);
			checkValue("reset outValid", 0, outValid);
			checkValue("reset done", 0, done);
			checkValue("reset outData", 0, outData);
			checkValue("reset outNode", 0, outNode);
			@(negedge clk);
		end
		reportTest("resetState", errorsBefore);

		for (int r = 0; r < numRecords; r++)
		begin
			errorsBefore = errorCount;
			name = $sformatf("record%0d", r);
			runRecord(r, 1'b0, 1'b0, name);
			reportTest(name, errorsBefore);
		end

		errorsBefore = errorCount;
		runRecord(3, 1'b0, 1'b1, "strobesWhileBusy");
		reportTest("strobesWhileBusy", errorsBefore);

		errorsBefore = errorCount;
		runRecord(4, 1'b1, 1'b0, "gappedInputs");
		reportTest("gappedInputs", errorsBefore);

		errorsBefore = errorCount;
		runRecord(1, 1'b1, 1'b1, "gapsAndStrobes");
		reportTest("gapsAndStrobes", errorsBefore);

		$display("Tests: %0d, failed: %0d, errors: %0d", testCount, failedTests, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* tests/denseLayer_vectors.txt */
// One record per line: activations 0 to 14, then expected outputs of neurons 0 to 3.
// Activations are 8-bit two's complement, outputs are the 16-bit ReLU results.
// All activations one.
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 0052 0000 0007 0000
// All activations minus one.
FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF 0000 0078 0000 00B4
// All zero, bias only.
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0000 0025 0000 0015
// Sparse mixed signs.
64 00 00 CE 00 00 00 00 14 00 00 00 00 00 F9 122F 0000 0000 04B0
// Extreme values, neuron 3 wraps past 16 bits.
00 00 00 80 00 00 00 00 80 00 00 00 00 00 7F 0067 0000 0A90 0000
// Ramp 1 to 15.
01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 0356 0000 0000 0000

/* sim.f */
hdl/nnTypesPkg.sv
hdl/nnWeightsPkg.sv
hdl/macBus.sv
hdl/layerControl.sv
hdl/stepCounter.sv
hdl/activationBuffer.sv
hdl/neuronMac.sv
hdl/denseLayer.sv
tests/denseLayer_assertions.sv
tests/denseLayerTb.sv

/* run.sh */
#!/bin/sh
# Build and run the denseLayer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f sim.f --top-module denseLayerTb -o denseLayerSim; then
	echo "Verilator build failed"
	exit 1
fi

if ! output=$(./obj_dir/denseLayerSim); then
	echo "$output"
	echo "Simulation exited with an error"
	exit 1
fi

echo "$output"
if echo "$output" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1
